// File: logic/gsharePkg.sv
// Types, constants and the index hash shared by the gshare predictor.
// The history must not be wider than the PHT index, since it is folded
// into the top index bits.
package gsharePkg;

    // Fetch or branch address.
    typedef logic [31:0] pcT;

    // PHT index, 256 entries.
    typedef logic [7:0] phtIndexT;

    // Global branch history.
    typedef logic [5:0] historyT;

    // 2-bit saturating counter. The top bit is the predicted direction.
    typedef logic [1:0] phtCounterT;

    localparam int PHT_INDEX_BITS = $bits(phtIndexT);
    localparam int HISTORY_BITS = $bits(historyT);
    localparam int PHT_ENTRY_COUNT = 1 << PHT_INDEX_BITS;

    // Counter limits.
    localparam phtCounterT COUNTER_MAX = 2'd3;
    localparam phtCounterT COUNTER_INIT = 2'd2;

    // Instructions are 4 bytes apart, so these PC bits carry no information.
    localparam int INSN_OFFSET_BITS = 2;

    // PC bits above the instruction offset, with the history XORed into
    // the top history-width bits of the index.
    function automatic phtIndexT phtHash(input pcT pc, input historyT history);
        phtIndexT index;
        index = pc[INSN_OFFSET_BITS +: PHT_INDEX_BITS];
        index[PHT_INDEX_BITS-1 -: HISTORY_BITS] =
            index[PHT_INDEX_BITS-1 -: HISTORY_BITS] ^ history;
        return index;
    endfunction

endpackage

// File: logic/phtBankedRam.sv
// Banked PHT storage with one registered read per port and one write port.
// Banks are picked by the low index bits; bankCount must be a power of two
// of at least 2. A read and a write of the same entry in one cycle return
// the old value. No two read ports may address the same bank in one cycle.
module phtBankedRam import gsharePkg::*; #(
    parameter int entryCount = PHT_ENTRY_COUNT,
    parameter int readPorts = 2,
    parameter int bankCount = 2
) (
    input  logic       clock,
    input  phtIndexT   readAddr [readPorts],
    output phtCounterT readData [readPorts],
    input  logic       writeEnable,
    input  phtIndexT   writeAddr,
    input  phtCounterT writeData
);

    localparam int bankBits = $clog2(bankCount);
    localparam int rowCount = entryCount / bankCount;
    localparam int rowBits = $clog2(rowCount);

    logic [bankBits-1:0] portBank [readPorts];
    logic [bankBits-1:0] portBankQ [readPorts];
    logic [rowBits-1:0] bankRow [bankCount];
    phtCounterT bankData [bankCount];
    logic [bankBits-1:0] writeBank;
    logic [rowBits-1:0] writeRow;
    logic bankConflict;

    assign writeBank = writeAddr[bankBits-1:0];
    assign writeRow = writeAddr[bankBits +: rowBits];

    always_comb begin
        for (int p = 0; p < readPorts; p++) begin
            portBank[p] = readAddr[p][bankBits-1:0];
        end
    end

    // Steer each port's row address to the bank it selects.
    always_comb begin
        for (int b = 0; b < bankCount; b++) begin
            bankRow[b] = '0;
            for (int p = 0; p < readPorts; p++) begin
                if (portBank[p] == bankBits'(b)) begin
                    bankRow[b] = readAddr[p][bankBits +: rowBits];
                end
            end
        end
    end

    for (genvar b = 0; b < bankCount; b++) begin : gBank
        phtCounterT mem [rowCount];
        phtCounterT rdData;

        always_ff @(posedge clock) begin
            if (writeEnable && writeBank == bankBits'(b)) begin
                mem[writeRow] <= writeData;
            end
            rdData <= mem[bankRow[b]];
        end

        assign bankData[b] = rdData;
    end

    // Remember which bank each port read, to pick its data next cycle.
    always_ff @(posedge clock) begin
        portBankQ <= portBank;
    end

    always_comb begin
        for (int p = 0; p < readPorts; p++) begin
            readData[p] = bankData[portBankQ[p]];
        end
    end

    always_comb begin
        bankConflict = 1'b0;
        for (int p = 0; p < readPorts; p++) begin
            for (int q = p + 1; q < readPorts; q++) begin
                if (portBank[p] == portBank[q]) begin
                    bankConflict = 1'b1;
                end
            end
        end
    end

    // Each bank has a single read port.
    assert property (@(posedge clock) !bankConflict)
        else $error("PHT read ports collide on one bank");

endmodule

// File: logic/phtUpdateQueue.sv
// Circular queue of deferred PHT writes. Entries come out in push order.
// A push while full is dropped; the depth need not be a power of two.
module phtUpdateQueue import gsharePkg::*; #(
    parameter int depth = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       push,
    input  logic       pop,
    input  phtIndexT   pushAddr,
    input  phtCounterT pushData,
    output phtIndexT   headAddr,
    output phtCounterT headData,
    output logic       full,
    output logic       empty
);

    localparam int ptrBits = (depth > 1) ? $clog2(depth) : 1;
    localparam int countBits = $clog2(depth + 1);

    logic [ptrBits-1:0] headPtr;
    logic [ptrBits-1:0] tailPtr;
    logic [countBits-1:0] count;
    logic doPush;
    logic doPop;

    phtIndexT addrMem [depth];
    phtCounterT dataMem [depth];

    // Pointer increment with wrap at the last slot.
    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        logic [ptrBits-1:0] result;
        if (ptr == ptrBits'(depth - 1)) begin
            result = '0;
        end else begin
            result = ptr + 1'b1;
        end
        return result;
    endfunction

    assign full = (count == countBits'(depth));
    assign empty = (count == '0);
    assign doPush = push && !full;
    assign doPop = pop && !empty;

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tailPtr <= nextPtr(tailPtr);
            end
            if (doPop) begin
                headPtr <= nextPtr(headPtr);
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage.
    always_ff @(posedge clock) begin
        if (doPush) begin
            addrMem[tailPtr] <= pushAddr;
            dataMem[tailPtr] <= pushData;
        end
    end

    // Oldest entry, valid whenever the queue is not empty.
    assign headAddr = addrMem[headPtr];
    assign headData = dataMem[headPtr];

    assert property (@(posedge clock) disable iff (reset) push |-> !full)
        else $error("PHT update queue overflow, update lost");

    assert property (@(posedge clock) disable iff (reset) pop |-> !empty)
        else $error("PHT update queue popped while empty");

endmodule

// File: logic/gshareCore.sv
// gshare core: history register, prediction, counter training, history repair,
// PHT write arbitration and the init walk over every PHT entry after reset.
// At most two resolved branches per cycle are trained; the lowest valid lane
// writes directly and the next one is deferred through the queue.
module gshareCore import gsharePkg::*; #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  pcT                    fetchPc,
    input  logic [fetchWidth-1:0] btbHit,
    input  logic [fetchWidth-1:0] isCondBr,
    input  logic [fetchWidth-1:0] historyUpdateEnable,
    input  logic [issueWidth-1:0] resValid,
    input  logic [issueWidth-1:0] resTaken,
    input  logic [issueWidth-1:0] resMispred,
    input  logic [issueWidth-1:0] resIsCondBr,
    input  pcT                    resPc [issueWidth],
    input  historyT               resHistory [issueWidth],
    input  phtCounterT            resPrevCounter [issueWidth],
    output logic [fetchWidth-1:0] predTaken,
    output phtCounterT            prevCounter [fetchWidth],
    output historyT               usedHistory,
    output logic                  ready,
    output phtIndexT              readAddr [fetchWidth],
    input  phtCounterT            readData [fetchWidth],
    output logic                  writeEnable,
    output phtIndexT              writeAddr,
    output phtCounterT            writeData,
    output logic                  push,
    output logic                  pop,
    output phtIndexT              pushAddr,
    output phtCounterT            pushData,
    input  phtIndexT              headAddr,
    input  phtCounterT            headData,
    input  logic                  empty
);

    historyT history;
    historyT nextHistory;
    logic [fetchWidth-1:0] btbHitQ;
    logic [fetchWidth-1:0] isCondBrQ;
    logic [fetchWidth-1:0] updateEnableQ;
    phtIndexT initIndex;
    logic initDone;
    logic [issueWidth-1:0] resActive;
    phtIndexT resIndex [issueWidth];
    phtCounterT resCounter [issueWidth];
    logic directWrite;
    phtIndexT directAddr;
    phtCounterT directData;

    // Saturating up/down step of a 2-bit counter.
    function automatic phtCounterT counterNext(input phtCounterT counter, input logic taken);
        phtCounterT result;
        if (taken) begin
            result = (counter == COUNTER_MAX) ? COUNTER_MAX : counter + 1'b1;
        end else begin
            result = (counter == '0) ? '0 : counter - 1'b1;
        end
        return result;
    endfunction

    assign ready = initDone;
    assign usedHistory = history;

    // Results are ignored until the walk is over.
    assign resActive = resValid & {issueWidth{initDone}};

    // Lane flags were registered with the read, so they line up with readData.
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            predTaken[i] = initDone && btbHitQ[i] &&
                (readData[i][$bits(phtCounterT)-1] || !isCondBrQ[i]);
            prevCounter[i] = readData[i];
        end
    end

    // Next history: speculative shifts first, then repair from execute.
    always_comb begin
        logic stopScan;
        stopScan = 1'b0;
        nextHistory = history;
        for (int i = 0; i < fetchWidth; i++) begin
            if (!stopScan && initDone && btbHitQ[i] && isCondBrQ[i] && updateEnableQ[i]) begin
                nextHistory = {nextHistory[HISTORY_BITS-2:0], predTaken[i]};
                // Lanes after a taken branch are not on the fetch path.
                stopScan = predTaken[i];
            end
        end
        // Later lanes are younger, so the last mispredict wins.
        for (int j = 0; j < issueWidth; j++) begin
            if (resActive[j] && resMispred[j]) begin
                if (resIsCondBr[j]) begin
                    nextHistory = {resHistory[j][HISTORY_BITS-2:0], resTaken[j]};
                end else begin
                    nextHistory = resHistory[j];
                end
            end
        end
    end

    // During the walk each lane reads its own bank to keep ports apart.
    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            if (initDone) begin
                readAddr[i] = phtHash(fetchPc + (pcT'(i) << INSN_OFFSET_BITS), nextHistory);
            end else begin
                readAddr[i] = phtIndexT'(i);
            end
        end
    end

    // Training. First valid result writes now, the next goes to the queue.
    always_comb begin
        directWrite = 1'b0;
        directAddr = '0;
        directData = '0;
        push = 1'b0;
        pushAddr = '0;
        pushData = '0;
        for (int j = 0; j < issueWidth; j++) begin
            resIndex[j] = phtHash(resPc[j], resHistory[j]);
            resCounter[j] = counterNext(resPrevCounter[j], resTaken[j]);
            if (resActive[j]) begin
                if (!directWrite) begin
                    directWrite = 1'b1;
                    directAddr = resIndex[j];
                    directData = resCounter[j];
                end else if (!push) begin
                    push = 1'b1;
                    pushAddr = resIndex[j];
                    pushData = resCounter[j];
                end
            end
        end
    end

    // Queue drains only into cycles with a free write port.
    assign pop = initDone && !empty && !directWrite;

    // Write port priority: init walk, direct write, queue head.
    always_comb begin
        if (!initDone) begin
            writeEnable = 1'b1;
            writeAddr = initIndex;
            writeData = COUNTER_INIT;
        end else if (directWrite) begin
            writeEnable = 1'b1;
            writeAddr = directAddr;
            writeData = directData;
        end else if (pop) begin
            writeEnable = 1'b1;
            writeAddr = headAddr;
            writeData = headData;
        end else begin
            writeEnable = 1'b0;
            writeAddr = directAddr;
            writeData = directData;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
            btbHitQ <= '0;
            isCondBrQ <= '0;
            updateEnableQ <= '0;
            initIndex <= '0;
            initDone <= 1'b0;
        end else begin
            history <= nextHistory;
            btbHitQ <= btbHit;
            isCondBrQ <= isCondBr;
            updateEnableQ <= historyUpdateEnable;
            // One entry per cycle, done after the last index.
            if (!initDone) begin
                initIndex <= initIndex + 1'b1;
                initDone <= (initIndex == '1);
            end
        end
    end

    // A queued update left over from before reset would land on a walked entry.
    assert property (@(posedge clock) disable iff (reset) !initDone |-> empty)
        else $error("PHT update queue not empty during the init walk");

endmodule

// File: logic/branchPredictUnit.sv
// Top level of the gshare direction predictor for a multi-wide fetch.
// Predictions follow the fetch inputs by one cycle. Fetch and result
// inputs are ignored until ready rises after the PHT init walk.
module branchPredictUnit import gsharePkg::*; #(
    parameter int fetchWidth = 2,
    parameter int issueWidth = 2,
    parameter int queueDepth = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  pcT                    fetchPc,
    input  logic [fetchWidth-1:0] btbHit,
    input  logic [fetchWidth-1:0] isCondBr,
    input  logic [fetchWidth-1:0] historyUpdateEnable,
    output logic [fetchWidth-1:0] predTaken,
    output phtCounterT            prevCounter [fetchWidth],
    output historyT               usedHistory,
    output logic                  ready,
    input  logic [issueWidth-1:0] resValid,
    input  pcT                    resPc [issueWidth],
    input  historyT               resHistory [issueWidth],
    input  phtCounterT            resPrevCounter [issueWidth],
    input  logic [issueWidth-1:0] resTaken,
    input  logic [issueWidth-1:0] resMispred,
    input  logic [issueWidth-1:0] resIsCondBr
);

    // One bank per fetch lane so neighbouring lanes never collide.
    localparam int bankCount = fetchWidth;

    phtIndexT readAddr [fetchWidth];
    phtCounterT readData [fetchWidth];
    logic writeEnable;
    phtIndexT writeAddr;
    phtCounterT writeData;
    logic push;
    logic pop;
    phtIndexT pushAddr;
    phtCounterT pushData;
    phtIndexT headAddr;
    phtCounterT headData;
    logic empty;

    gshareCore #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth)
    ) core_i (
        .clock(clock),
        .reset(reset),
        .fetchPc(fetchPc),
        .btbHit(btbHit),
        .isCondBr(isCondBr),
        .historyUpdateEnable(historyUpdateEnable),
        .resValid(resValid),
        .resTaken(resTaken),
        .resMispred(resMispred),
        .resIsCondBr(resIsCondBr),
        .resPc(resPc),
        .resHistory(resHistory),
        .resPrevCounter(resPrevCounter),
        .predTaken(predTaken),
        .prevCounter(prevCounter),
        .usedHistory(usedHistory),
        .ready(ready),
        .readAddr(readAddr),
        .readData(readData),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData),
        .push(push),
        .pop(pop),
        .pushAddr(pushAddr),
        .pushData(pushData),
        .headAddr(headAddr),
        .headData(headData),
        .empty(empty)
    );

    phtBankedRam #(
        .entryCount(PHT_ENTRY_COUNT),
        .readPorts(fetchWidth),
        .bankCount(bankCount)
    ) phtRam_i (
        .clock(clock),
        .readAddr(readAddr),
        .readData(readData),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeData(writeData)
    );

    // Full is checked inside the queue itself.
    phtUpdateQueue #(
        .depth(queueDepth)
    ) updateQueue_i (
        .clock(clock),
        .reset(reset),
        .push(push),
        .pop(pop),
        .pushAddr(pushAddr),
        .pushData(pushData),
        .headAddr(headAddr),
        .headData(headData),
        .full(),
        .empty(empty)
    );

endmodule

// File: tests/branchPredictTb.sv
// Testbench for the gshare predictor, driven from tests/gshareTrace.txt.
// Each trace line is one cycle of inputs plus the outputs expected in the
// following cycle. Run from the project root so the trace path resolves.
module branchPredictTb import gsharePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int fetchWidth = 2;
    localparam int issueWidth = 2;
    localparam int queueDepth = 4;
    localparam int clockPeriod = 40;
    localparam int readyTimeout = 400;
    localparam int maxLines = 1000;
    localparam int fieldCount = 20;

    logic clock;
    logic reset;
    pcT fetchPc;
    logic [fetchWidth-1:0] btbHit;
    logic [fetchWidth-1:0] isCondBr;
    logic [fetchWidth-1:0] historyUpdateEnable;
    logic [fetchWidth-1:0] predTaken;
    phtCounterT prevCounter [fetchWidth];
    historyT usedHistory;
    logic ready;
    logic [issueWidth-1:0] resValid;
    pcT resPc [issueWidth];
    historyT resHistory [issueWidth];
    phtCounterT resPrevCounter [issueWidth];
    logic [issueWidth-1:0] resTaken;
    logic [issueWidth-1:0] resMispred;
    logic [issueWidth-1:0] resIsCondBr;

    int checkCount;
    int errorCount;
    int testChecks;
    int testErrors;
    int currentTest;
    int f [fieldCount];
    logic havePending;
    int pendCompare;
    int pendPred;
    int pendCounter0;
    int pendCounter1;
    int pendHistory;

    branchPredictUnit #(
        .fetchWidth(fetchWidth),
        .issueWidth(issueWidth),
        .queueDepth(queueDepth)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .fetchPc(fetchPc),
        .btbHit(btbHit),
        .isCondBr(isCondBr),
        .historyUpdateEnable(historyUpdateEnable),
        .predTaken(predTaken),
        .prevCounter(prevCounter),
        .usedHistory(usedHistory),
        .ready(ready),
        .resValid(resValid),
        .resPc(resPc),
        .resHistory(resHistory),
        .resPrevCounter(resPrevCounter),
        .resTaken(resTaken),
        .resMispred(resMispred),
        .resIsCondBr(resIsCondBr)
    );

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        testChecks++;
        if (actual !== expected) begin
            errorCount++;
            testErrors++;
            $display("error at %0t ns: %s got %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    // Outputs now reflect the previous trace line.
    task automatic checkPending();
        if (havePending) begin
            // Ready stays high once the walk is over.
            checkValue("ready", 32'(ready), 32'd1);
        end
        if (havePending && pendCompare != 0) begin
            checkValue("predTaken", 32'(predTaken), pendPred);
            checkValue("prevCounter[0]", 32'(prevCounter[0]), pendCounter0);
            checkValue("prevCounter[1]", 32'(prevCounter[1]), pendCounter1);
            checkValue("usedHistory", 32'(usedHistory), pendHistory);
        end
    endtask

    task automatic reportTest();
        $display("test %0d finished: %0d checks, %0d errors", currentTest, testChecks,
                 testErrors);
    endtask

    task automatic driveLine();
        fetchPc = pcT'(f[1]);
        btbHit = 2'(f[2]);
        isCondBr = 2'(f[3]);
        historyUpdateEnable = 2'(f[4]);
        resValid = 2'(f[5]);
        resPc[0] = pcT'(f[6]);
        resHistory[0] = historyT'(f[7]);
        resPrevCounter[0] = phtCounterT'(f[8]);
        resPc[1] = pcT'(f[9]);
        resHistory[1] = historyT'(f[10]);
        resPrevCounter[1] = phtCounterT'(f[11]);
        resTaken = 2'(f[12]);
        resMispred = 2'(f[13]);
        resIsCondBr = 2'(f[14]);
        pendCompare = f[15];
        pendPred = f[16];
        pendCounter0 = f[17];
        pendCounter1 = f[18];
        pendHistory = f[19];
        havePending = 1'b1;
    endtask

    initial begin
        int fd;
        int got;
        int parsed;
        int lineCount;
        int waitCycles;
        logic aborted;
        string line;

        reset = 1'b1;
        fetchPc = '0;
        btbHit = '0;
        isCondBr = '0;
        historyUpdateEnable = '0;
        resValid = '0;
        resTaken = '0;
        resMispred = '0;
        resIsCondBr = '0;
        for (int j = 0; j < issueWidth; j++) begin
            resPc[j] = '0;
            resHistory[j] = '0;
            resPrevCounter[j] = '0;
        end
        checkCount = 0;
        errorCount = 0;
        testChecks = 0;
        testErrors = 0;
        currentTest = -1;
        havePending = 1'b0;
        aborted = 1'b0;
        lineCount = 0;

        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;

        // The init walk takes one cycle per PHT entry.
        waitCycles = 0;
        while (!ready && waitCycles < readyTimeout) begin
            @(posedge clock);
            #2;
            waitCycles++;
        end

        if (!ready) begin
            $display("Timeout: ready did not rise within %0d cycles", readyTimeout);
            aborted = 1'b1;
        end else begin
            checkValue("init walk cycles", 32'(waitCycles), 32'(PHT_ENTRY_COUNT));
            fd = $fopen("tests/gshareTrace.txt", "r");
            if (fd == 0) begin
                $display("Could not open the trace file tests/gshareTrace.txt");
                aborted = 1'b1;
            end else begin
                while (!$feof(fd) && lineCount < maxLines) begin
                    got = $fgets(line, fd);
                    parsed = 0;
                    if (got > 0 && line.getc(0) != "#") begin
                        parsed = $sscanf(line,
                            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                            f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
                            f[18], f[19]);
                    end
                    if (parsed == fieldCount) begin
                        @(posedge clock);
                        #2;
                        checkPending();
                        if (f[0] != currentTest) begin
                            if (currentTest >= 0) begin
                                reportTest();
                            end
                            currentTest = f[0];
                            testChecks = 0;
                            testErrors = 0;
                        end
                        driveLine();
                        lineCount++;
                    end
                end
                $fclose(fd);
                if (lineCount >= maxLines) begin
                    $display("Trace is longer than %0d cycles, run stopped", maxLines);
                    aborted = 1'b1;
                end
                // One more cycle to see the last line's outputs.
                @(posedge clock);
                #2;
                checkPending();
                if (currentTest >= 0) begin
                    reportTest();
                end else begin
                    $display("Trace file holds no stimulus lines");
                    aborted = 1'b1;
                end
            end
        end

        $display("Totals: %0d checks, %0d errors", checkCount, errorCount);
        if (aborted || errorCount != 0) begin
            $display("Regression failed");
        end else begin
            $display("Regression passed");
        end
        $finish;
    end

endmodule

// File: tests/gshareTrace.txt
# test pc btb cond hue resValid pc0 hist0 prev0 pc1 hist1 prev1 taken mispred resCond
# compare expPredTaken expPrev0 expPrev1 expHistory (outputs of the next cycle), all hex
1 100 1 3 0 0 0 0 0 0 0 0 0 0 0 1 1 2 2 00
1 200 3 2 0 0 0 0 0 0 0 0 0 0 0 1 3 2 2 00
2 0 0 0 0 1 40 0 2 0 0 0 0 0 1 0 0 0 0 00
2 0 0 0 0 1 40 0 1 0 0 0 0 0 1 0 0 0 0 00
2 40 1 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 2 00
2 0 0 0 0 1 40 0 0 0 0 0 0 0 1 0 0 0 0 00
2 40 1 1 0 0 0 0 0 0 0 0 0 0 0 1 0 0 2 00
2 0 0 0 0 1 40 0 0 0 0 0 1 0 1 0 0 0 0 00
2 0 0 0 0 1 40 0 1 0 0 0 1 0 1 0 0 0 0 00
2 0 0 0 0 1 40 0 2 0 0 0 1 0 1 0 0 0 0 00
2 0 0 0 0 1 40 0 3 0 0 0 1 0 1 0 0 0 0 00
2 40 1 1 0 0 0 0 0 0 0 0 0 0 0 1 1 3 2 00
3 0 0 0 0 1 80 0 2 0 0 0 0 0 1 0 0 0 0 00
3 0 0 0 0 1 80 0 1 0 0 0 0 0 1 0 0 0 0 00
3 200 3 3 3 0 0 0 0 0 0 0 0 0 0 1 3 2 2 00
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 2 2 01
3 90 3 3 3 0 0 0 0 0 0 0 0 0 0 1 2 0 2 01
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 2 2 05
4 0 0 0 0 1 300 2a 2 0 0 0 1 1 1 1 0 2 2 15
4 0 0 0 0 1 304 33 2 0 0 0 1 1 0 1 0 2 2 33
4 0 0 0 0 3 308 01 2 30c 2c 2 1 3 1 1 0 2 2 2c
5 0 0 0 0 3 100 0 2 180 0 2 2 0 3 1 0 2 2 2c
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00
5 3c0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 2 2c
5 340 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 3 2 2c
5 30c 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 2 2c

// File: files.f
logic/gsharePkg.sv
logic/phtBankedRam.sv
logic/phtUpdateQueue.sv
logic/gshareCore.sv
logic/branchPredictUnit.sv
tests/branchPredictTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds and runs the gshare predictor testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module branchPredictTb \
    -f files.f \
    -o simBranchPredict

simOutput=$(./obj_dir/simBranchPredict)
echo "$simOutput"

if grep -q "Regression passed" <<< "$simOutput"; then
    exit 0
else
    exit 1
fi
